// ==== filelist.f ====
source/tensor_pkg.sv
source/instr_pkg.sv
source/operand_capture.sv
source/mac_lane.sv
source/mac_array.sv
source/tensor_stripe.sv
tb/tb_tensor_stripe.sv

// ==== source/instr_pkg.sv ====
package instr_pkg;

  // Per-lane term selection
  typedef enum logic [1:0] {
    OP_ADD     = 2'd0,  // a + b
    OP_ABSDIFF = 2'd1,  // |a - b|
    OP_MUL     = 2'd2   // a * b
  } opcode_e;

  // Seven-bit instruction word, op in the top bits
  typedef struct packed {
    opcode_e    op;
    logic       accumulate;    // 1 adds the term, 0 overwrites
    logic       scalar_en;     // Broadcast one A element to all lanes
    logic [2:0] scalar_index;  // Which A element when broadcasting
  } instr_t;

endpackage

// ==== source/mac_array.sv ====
`timescale 1ns/1ps

module mac_array #(
  parameter int LANES = 8,
  parameter int TAG_W = 12
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                cfg_valid,
  input  logic [TAG_W-1:0]                    cfg_iter_limit,
  input  instr_pkg::instr_t                   cfg_instr,
  input  logic [LANES*tensor_pkg::DATA_W-1:0] a_block,
  input  logic [LANES*tensor_pkg::DATA_W-1:0] b_block,
  input  logic                                a_full,
  input  logic                                b_full,
  input  logic                                result_ready,
  output logic                                fire,
  output logic                                result_valid,
  output logic [LANES*tensor_pkg::DATA_W-1:0] result_data
);

  import tensor_pkg::*;
  import instr_pkg::*;

  instr_t           instr_q;
  logic [TAG_W-1:0] iter_limit;
  logic [TAG_W-1:0] iter_count;
  logic [TAG_W-1:0] iter_next;
  elem_t            a_elem [LANES];
  elem_t            b_elem [LANES];
  elem_t            lane_a [LANES];
  elem_t            scalar_elem;

  // Both operands present and iterations left
  assign fire      = a_full && b_full && (iter_count < iter_limit);
  assign iter_next = iter_count + 1'b1;

  // Instruction and iteration limit, loaded by a configuration write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr_q    <= '0;
      iter_limit <= '0;
    end else if (cfg_valid) begin
      instr_q    <= cfg_instr;
      iter_limit <= cfg_iter_limit;
    end
  end

  // Iteration counter and result handshake
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      iter_count   <= '0;
      result_valid <= 1'b0;
    end else if (cfg_valid) begin
      iter_count   <= '0;
      result_valid <= 1'b0;
    end else if (fire) begin
      iter_count <= iter_next;
      if (iter_next == iter_limit) begin
        result_valid <= 1'b1;  // Last iteration lands this edge
      end
    end else if (result_valid && result_ready) begin
      result_valid <= 1'b0;  // Count stays at limit until next config
    end
  end

  // Slice the blocks into elements
  for (genvar i = 0; i < LANES; i++) begin : g_slice
    assign a_elem[i] = a_block[i*DATA_W +: DATA_W];
    assign b_elem[i] = b_block[i*DATA_W +: DATA_W];
  end

  assign scalar_elem = a_elem[instr_q.scalar_index];

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // Scalar mode feeds one A element to every lane
    assign lane_a[i] = instr_q.scalar_en ? scalar_elem : a_elem[i];

    mac_lane i_mac_lane (
      .clk         (clk),
      .arst_n      (arst_n),
      .clear       (cfg_valid),
      .step        (fire),
      .instr       (instr_q),
      .a_elem      (lane_a[i]),
      .b_elem      (b_elem[i]),
      .result_elem (result_data[i*DATA_W +: DATA_W])
    );
  end

endmodule

// ==== source/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               clear,
  input  logic               step,
  input  instr_pkg::instr_t  instr,
  input  tensor_pkg::elem_t  a_elem,
  input  tensor_pkg::elem_t  b_elem,
  output tensor_pkg::elem_t  result_elem
);

  import tensor_pkg::*;
  import instr_pkg::*;

  localparam int MAG_W = DATA_W - 1;

  acc_t             a_val;
  acc_t             b_val;
  acc_t             diff;
  acc_t             term;
  acc_t             acc;
  logic [ACC_W-1:0] acc_abs;
  logic             acc_neg;

  // Sign-magnitude to two's complement
  always_comb begin
    a_val = acc_t'(a_elem[MAG_W-1:0]);
    b_val = acc_t'(b_elem[MAG_W-1:0]);
    if (a_elem[DATA_W-1]) a_val = -a_val;
    if (b_elem[DATA_W-1]) b_val = -b_val;
  end

  assign diff = a_val - b_val;

  always_comb begin
    case (instr.op)
      OP_ADD:     term = a_val + b_val;
      OP_ABSDIFF: term = diff[ACC_W-1] ? -diff : diff;
      OP_MUL:     term = a_val * b_val;  // Fits, both magnitudes are 15 bits
      default:    term = '0;
    endcase
  end

  // Clear wins over a simultaneous step
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;
    end else if (step) begin
      if (instr.accumulate) begin
        acc <= acc + term;
      end else begin
        acc <= term;
      end
    end
  end

  // Back to sign-magnitude with saturation
  assign acc_neg = acc[ACC_W-1];
  assign acc_abs = acc_neg ? -acc : acc;  // -2^31 still reads as 2^31 unsigned

  always_comb begin
    result_elem[DATA_W-1] = acc_neg;
    if (acc_abs > MAG_MAX) begin
      result_elem[MAG_W-1:0] = MAG_W'(MAG_MAX);
    end else begin
      result_elem[MAG_W-1:0] = acc_abs[MAG_W-1:0];
    end
  end

endmodule

// ==== source/operand_capture.sv ====
`timescale 1ns/1ps

module operand_capture #(
  parameter int TAG_W = 12,
  parameter int LANES = 8
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                cfg_valid,
  input  logic [TAG_W-1:0]                    cfg_tag,
  input  logic [TAG_W-1:0]                    cfg_stride,
  input  logic                                bus_valid,
  input  logic [TAG_W-1:0]                    bus_tag,
  input  logic [LANES*tensor_pkg::DATA_W-1:0] bus_data,
  input  logic                                fire,
  output logic [LANES*tensor_pkg::DATA_W-1:0] block,
  output logic                                full
);

  import tensor_pkg::*;

  localparam int BLOCK_W = LANES * DATA_W;

  logic [TAG_W-1:0] tag;
  logic [TAG_W-1:0] stride;
  logic             match;

  // Only an empty capture listens to the bus
  assign match = bus_valid && !full && (bus_tag == tag);

  // Tag, stride and full flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tag    <= '0;
      stride <= '0;
      full   <= 1'b0;
    end else if (cfg_valid) begin
      tag    <= cfg_tag;
      stride <= cfg_stride;
      full   <= 1'b0;
    end else if (fire) begin
      full <= 1'b0;
      tag  <= tag + stride;  // Wraps at TAG_W bits
    end else if (match) begin
      full <= 1'b1;
    end
  end

  // Operand payload, held until the array consumes it
  always_ff @(posedge clk) begin
    if (match && !cfg_valid) begin
      block <= bus_data[BLOCK_W-1:0];
    end
  end

endmodule

// ==== source/tensor_pkg.sv ====
package tensor_pkg;

  // Element format is sign-magnitude
  // Bit 15 carries the sign, bits 14..0 the magnitude
  localparam int DATA_W = 16;

  // Default stripe geometry
  localparam int LANES = 8;   // Elements per block
  localparam int TAG_W = 12;  // Tag and stride width

  // Integer accumulation
  localparam int ACC_W = 32;

  // Largest magnitude a 15-bit field can hold
  localparam int MAG_MAX = 32767;

  // One bus element
  typedef logic [DATA_W-1:0] elem_t;

  // Two's complement accumulator, wraps modulo 2^32
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// ==== source/tensor_stripe.sv ====
`timescale 1ns/1ps

module tensor_stripe #(
  parameter int LANES = tensor_pkg::LANES,
  parameter int TAG_W = tensor_pkg::TAG_W
) (
  input  logic                                clk,
  input  logic                                arst_n,
  // Configuration write, always accepted
  input  logic                                cfg_valid,
  input  logic [TAG_W-1:0]                    cfg_tag_a,
  input  logic [TAG_W-1:0]                    cfg_tag_b,
  input  logic [TAG_W-1:0]                    cfg_stride_a,
  input  logic [TAG_W-1:0]                    cfg_stride_b,
  input  logic [TAG_W-1:0]                    cfg_iter_limit,
  input  instr_pkg::instr_t                   cfg_instr,
  // Broadcast bus, no back-pressure
  input  logic                                bus_valid,
  input  logic [TAG_W-1:0]                    bus_tag,
  input  logic [LANES*tensor_pkg::DATA_W-1:0] bus_data,
  // Result beat
  input  logic                                result_ready,
  output logic                                result_valid,
  output logic [LANES*tensor_pkg::DATA_W-1:0] result_data
);

  import tensor_pkg::*;

  logic [LANES*DATA_W-1:0] a_block;
  logic [LANES*DATA_W-1:0] b_block;
  logic                    a_full;
  logic                    b_full;
  logic                    fire;

  // Operand A capture
  operand_capture #(
    .TAG_W (TAG_W),
    .LANES (LANES)
  ) i_capture_a (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_valid  (cfg_valid),
    .cfg_tag    (cfg_tag_a),
    .cfg_stride (cfg_stride_a),
    .bus_valid  (bus_valid),
    .bus_tag    (bus_tag),
    .bus_data   (bus_data),
    .fire       (fire),
    .block      (a_block),
    .full       (a_full)
  );

  // Operand B capture, same bus
  operand_capture #(
    .TAG_W (TAG_W),
    .LANES (LANES)
  ) i_capture_b (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_valid  (cfg_valid),
    .cfg_tag    (cfg_tag_b),
    .cfg_stride (cfg_stride_b),
    .bus_valid  (bus_valid),
    .bus_tag    (bus_tag),
    .bus_data   (bus_data),
    .fire       (fire),
    .block      (b_block),
    .full       (b_full)
  );

  mac_array #(
    .LANES (LANES),
    .TAG_W (TAG_W)
  ) i_mac_array (
    .clk            (clk),
    .arst_n         (arst_n),
    .cfg_valid      (cfg_valid),
    .cfg_iter_limit (cfg_iter_limit),
    .cfg_instr      (cfg_instr),
    .a_block        (a_block),
    .b_block        (b_block),
    .a_full         (a_full),
    .b_full         (b_full),
    .result_ready   (result_ready),
    .fire           (fire),
    .result_valid   (result_valid),
    .result_data    (result_data)
  );

endmodule

// ==== tb/tb_tensor_stripe.sv ====
`timescale 1ns/1ps

module tb_tensor_stripe;

  import tensor_pkg::*;
  import instr_pkg::*;

  localparam int BLOCK_W       = LANES * DATA_W;
  localparam int NROWS         = 6;
  localparam int MAX_ITER      = 4;
  localparam int IDLE_CYCLES   = 20;
  localparam int VALID_TIMEOUT = 40;
  localparam int READY_TIMEOUT = 200;
  localparam logic [TAG_W-1:0] DECOY_TAG = 12'habc;  // Never used by a row

  logic               clk;
  logic               arst_n;
  logic               cfg_valid;
  logic [TAG_W-1:0]   cfg_tag_a;
  logic [TAG_W-1:0]   cfg_tag_b;
  logic [TAG_W-1:0]   cfg_stride_a;
  logic [TAG_W-1:0]   cfg_stride_b;
  logic [TAG_W-1:0]   cfg_iter_limit;
  instr_t             cfg_instr;
  logic               bus_valid;
  logic [TAG_W-1:0]   bus_tag;
  logic [BLOCK_W-1:0] bus_data;
  logic               result_ready;
  logic               result_valid;
  logic [BLOCK_W-1:0] result_data;

  // Stimulus table
  logic [TAG_W-1:0]   row_tag_a    [NROWS];
  logic [TAG_W-1:0]   row_tag_b    [NROWS];
  logic [TAG_W-1:0]   row_stride_a [NROWS];
  logic [TAG_W-1:0]   row_stride_b [NROWS];
  logic [TAG_W-1:0]   row_limit    [NROWS];
  instr_t             row_instr    [NROWS];
  bit                 row_decoy    [NROWS];
  logic [BLOCK_W-1:0] row_a        [NROWS][MAX_ITER];
  logic [BLOCK_W-1:0] row_b        [NROWS][MAX_ITER];
  logic [BLOCK_W-1:0] row_exp      [NROWS];

  logic [31:0] lfsr_state = 32'h7b28;
  int          checks;
  int          value_errors;
  int          other_errors;
  bit          expect_idle;  // result_valid must stay low while set
  bit          timed_out;

  tensor_stripe #(
    .LANES (LANES),
    .TAG_W (TAG_W)
  ) i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .cfg_valid      (cfg_valid),
    .cfg_tag_a      (cfg_tag_a),
    .cfg_tag_b      (cfg_tag_b),
    .cfg_stride_a   (cfg_stride_a),
    .cfg_stride_b   (cfg_stride_b),
    .cfg_iter_limit (cfg_iter_limit),
    .cfg_instr      (cfg_instr),
    .bus_valid      (bus_valid),
    .bus_tag        (bus_tag),
    .bus_data       (bus_data),
    .result_ready   (result_ready),
    .result_valid   (result_valid),
    .result_data    (result_data)
  );

  always #10 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] res;
    res = '0;
    repeat (n) res = {res[30:0], lfsr_bit()};
    return res;
  endfunction

  function automatic instr_t make_instr(input opcode_e op, input logic acc,
                                        input logic sen, input logic [2:0] idx);
    instr_t ins;
    ins.op           = op;
    ins.accumulate   = acc;
    ins.scalar_en    = sen;
    ins.scalar_index = idx;
    return ins;
  endfunction

  function automatic int sm_value(input logic [DATA_W-1:0] e);
    int mag;
    mag = int'(e[DATA_W-2:0]);
    return e[DATA_W-1] ? -mag : mag;
  endfunction

  // Reference model of the lane rules
  function automatic logic [BLOCK_W-1:0] expected_block(input int r);
    logic [BLOCK_W-1:0] res;
    instr_t             ins;
    int                 acc;
    int                 a_v;
    int                 b_v;
    int                 term;
    int                 idx;
    longint             mag;
    logic               neg;
    res = '0;
    ins = row_instr[r];
    for (int l = 0; l < LANES; l++) begin
      acc = 0;
      for (int it = 0; it < int'(row_limit[r]); it++) begin
        idx = ins.scalar_en ? int'(ins.scalar_index) : l;
        a_v = sm_value(row_a[r][it][idx*DATA_W +: DATA_W]);
        b_v = sm_value(row_b[r][it][l*DATA_W +: DATA_W]);
        case (ins.op)
          OP_ADD:     term = a_v + b_v;
          OP_ABSDIFF: term = (a_v > b_v) ? a_v - b_v : b_v - a_v;
          OP_MUL:     term = a_v * b_v;
          default:    term = 0;
        endcase
        acc = ins.accumulate ? acc + term : term;  // 32-bit wrap
      end
      neg = (acc < 0);
      mag = neg ? -longint'(acc) : longint'(acc);
      if (mag > MAG_MAX) mag = MAG_MAX;
      res[l*DATA_W +: DATA_W] = {neg, mag[DATA_W-2:0]};
    end
    return res;
  endfunction

  task automatic set_cfg(input int r, input logic [TAG_W-1:0] tag_a,
                         input logic [TAG_W-1:0] tag_b, input logic [TAG_W-1:0] sa,
                         input logic [TAG_W-1:0] sb, input logic [TAG_W-1:0] limit,
                         input instr_t ins, input bit decoy);
    row_tag_a[r]    = tag_a;
    row_tag_b[r]    = tag_b;
    row_stride_a[r] = sa;
    row_stride_b[r] = sb;
    row_limit[r]    = limit;
    row_instr[r]    = ins;
    row_decoy[r]    = decoy;
  endtask

  // Element i gets magnitude base + step*i and sign bit i
  task automatic fill_pattern(input int r, input int it, input bit is_b, input int base,
                              input int step, input logic [7:0] signs);
    logic [BLOCK_W-1:0] blk;
    logic [31:0]        mag;
    for (int i = 0; i < LANES; i++) begin
      mag = base + step * i;
      blk[i*DATA_W +: DATA_W] = {signs[i], mag[DATA_W-2:0]};
    end
    if (is_b) begin
      row_b[r][it] = blk;
    end else begin
      row_a[r][it] = blk;
    end
  endtask

  task automatic fill_random(input int r);
    logic [31:0] mag;
    for (int it = 0; it < MAX_ITER; it++) begin
      for (int i = 0; i < LANES; i++) begin
        mag = lfsr_bits(10);
        row_a[r][it][i*DATA_W +: DATA_W] = {lfsr_bit(), mag[DATA_W-2:0]};
        mag = lfsr_bits(10);
        row_b[r][it][i*DATA_W +: DATA_W] = {lfsr_bit(), mag[DATA_W-2:0]};
      end
    end
  endtask

  task automatic build_table();
    set_cfg(0, 12'h010, 12'h020, 12'd1, 12'd1, 12'd1, make_instr(OP_ADD, 0, 0, 0), 0);
    fill_pattern(0, 0, 0, 100, 37, 8'ha6);  // Mixed signs
    fill_pattern(0, 0, 1, 250, 11, 8'h6c);
    set_cfg(1, 12'h100, 12'h200, 12'd3, 12'd7, 12'd3, make_instr(OP_MUL, 1, 0, 0), 1);
    fill_random(1);
    set_cfg(2, 12'h300, 12'h301, 12'd2, 12'd2, 12'd2, make_instr(OP_ABSDIFF, 1, 0, 0), 0);
    fill_pattern(2, 0, 0, 20000, 1000, 8'h0f);
    fill_pattern(2, 0, 1, 15000, 500, 8'hf0);
    fill_pattern(2, 1, 0, 100, 100, 8'h00);
    fill_pattern(2, 1, 1, 50, 300, 8'hff);
    set_cfg(3, 12'h050, 12'h060, 12'd0, 12'd0, 12'd1, make_instr(OP_MUL, 0, 0, 0), 0);
    fill_pattern(3, 0, 0, 100, 60, 8'h55);  // Lane 0 stays below the bound
    fill_pattern(3, 0, 1, 200, 30, 8'h0f);
    set_cfg(4, 12'hffe, 12'h400, 12'd3, 12'd5, 12'd2, make_instr(OP_MUL, 1, 1, 5), 0);
    fill_random(4);  // A tag wraps past 12'hfff
    set_cfg(5, 12'h7f0, 12'h7f1, 12'd2, 12'd2, 12'd4, make_instr(OP_ADD, 1, 0, 0), 1);
    fill_random(5);
    for (int r = 0; r < NROWS; r++) begin
      row_exp[r] = expected_block(r);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
    if (expect_idle) begin
      checks++;
      if (result_valid !== 1'b0) begin
        value_errors++;
        $display("error result_valid: got %h, expected %h", result_valid, 1'b0);
      end
    end
  endtask

  task automatic send_beat(input logic [TAG_W-1:0] tag, input logic [BLOCK_W-1:0] data);
    bus_valid = 1'b1;
    bus_tag   = tag;
    bus_data  = data;
    next_cycle();
    bus_valid = 1'b0;
  endtask

  task automatic collect_result(input int r);
    int waited;
    bit done;
    waited = 0;
    done   = 0;
    while (result_valid !== 1'b1 && waited < VALID_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (result_valid !== 1'b1) begin
      other_errors++;
      timed_out = 1;
      $display("Row %0d: result_valid did not rise within %0d cycles", r, VALID_TIMEOUT);
      return;
    end
    waited = 0;
    while (!done && waited < READY_TIMEOUT) begin
      checks++;
      if (result_valid !== 1'b1) begin  // Held until the handshake
        value_errors++;
        $display("error result_valid: got %h, expected %h", result_valid, 1'b1);
      end
      checks++;
      if (result_data !== row_exp[r]) begin  // Must hold while valid waits
        value_errors++;
        $display("error result_data row %0d: got %h, expected %h",
                 r, result_data, row_exp[r]);
      end
      result_ready = lfsr_bit();
      @(posedge clk);
      done = result_ready;
      #2;
      result_ready = 1'b0;
      waited++;
    end
    if (!done) begin
      other_errors++;
      timed_out = 1;
      $display("Row %0d: result beat never completed", r);
      return;
    end
    expect_idle = 1;  // Low until the next row's last iteration
    checks++;
    if (result_valid !== 1'b0) begin
      value_errors++;
      $display("error result_valid: got %h, expected %h", result_valid, 1'b0);
    end
  endtask

  task automatic run_row(input int r);
    logic [TAG_W-1:0] tag_a;
    logic [TAG_W-1:0] tag_b;
    cfg_valid      = 1'b1;
    cfg_tag_a      = row_tag_a[r];
    cfg_tag_b      = row_tag_b[r];
    cfg_stride_a   = row_stride_a[r];
    cfg_stride_b   = row_stride_b[r];
    cfg_iter_limit = row_limit[r];
    cfg_instr      = row_instr[r];
    next_cycle();
    cfg_valid = 1'b0;
    tag_a = row_tag_a[r];
    tag_b = row_tag_b[r];
    for (int it = 0; it < int'(row_limit[r]); it++) begin
      if (row_decoy[r]) send_beat(DECOY_TAG, ~row_a[r][it]);  // Both captures empty
      send_beat(tag_a, row_a[r][it]);
      if (row_decoy[r]) send_beat(DECOY_TAG, ~row_b[r][it]);  // Only B empty
      send_beat(tag_b, row_b[r][it]);
      tag_a = tag_a + row_stride_a[r];
      tag_b = tag_b + row_stride_b[r];
      if (it == int'(row_limit[r]) - 1) expect_idle = 0;
      next_cycle();  // Fire cycle, tags advance at its end
    end
    collect_result(r);
  endtask

  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    cfg_valid      = 1'b0;
    cfg_tag_a      = '0;
    cfg_tag_b      = '0;
    cfg_stride_a   = '0;
    cfg_stride_b   = '0;
    cfg_iter_limit = '0;
    cfg_instr      = '0;
    bus_valid      = 1'b0;
    bus_tag        = '0;
    bus_data       = '0;
    result_ready   = 1'b0;
    checks         = 0;
    value_errors   = 0;
    other_errors   = 0;
    expect_idle    = 1;
    timed_out      = 0;
    build_table();
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    // Beats at the reset tag fill both captures yet no result may appear
    for (int n = 0; n < IDLE_CYCLES; n++) begin
      send_beat((n % 4 == 0) ? '0 : TAG_W'(lfsr_bits(TAG_W)), {4{lfsr_bits(32)}});
    end
    for (int r = 0; r < NROWS; r++) begin
      if (!timed_out) run_row(r);
    end
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
